// File: logic/order_book_defs.svh
/* order book sizes */
`ifndef ORDER_BOOK_DEFS_SVH
`define ORDER_BOOK_DEFS_SVH

// stocks held by the book
`define NUM_STOCKS 4

// resting orders per stock and side
`define BOOK_DEPTH 8

// field widths
`define PRICE_W 32
`define QTY_W 16
`define OID_W 32

`endif

// File: logic/order_book_pkg.sv
/* order book types */
`include "order_book_defs.svh"

package order_book_pkg;

    typedef logic [$clog2(`NUM_STOCKS)-1:0] stock_t;
    typedef logic [$clog2(`BOOK_DEPTH)-1:0] slot_t;
    // one bit wider than slot_t so a full side fits
    typedef logic [$clog2(`BOOK_DEPTH):0]   count_t;
    typedef logic [`PRICE_W-1:0]            price_t;
    typedef logic [`QTY_W-1:0]              qty_t;
    typedef logic [`OID_W-1:0]              oid_t;

    typedef enum logic [1:0] {
        OP_ADD     = 2'd0,
        OP_CANCEL  = 2'd1,
        OP_EXECUTE = 2'd2
    } op_t;

    // bid is the buy side
    typedef enum logic {
        SIDE_ASK = 1'b0,
        SIDE_BID = 1'b1
    } side_t;

    typedef enum logic [1:0] {
        ST_OK        = 2'd0,
        ST_NOT_FOUND = 2'd1,
        ST_FULL      = 2'd2,
        ST_BAD_OP    = 2'd3
    } status_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADD,
        S_SEARCH,
        S_SHIFT,
        S_SCAN,
        S_DONE
    } ctrl_state_t;

endpackage

// File: logic/book_if.sv
/* controller to datapath link */
`timescale 1ns/100ps

interface book_if import order_book_pkg::*; ();

    // addressed side and slot
    side_t  side;
    stock_t stock;
    slot_t  slot;

    // write strobes
    logic   wr_add;
    logic   wr_dec;
    logic   wr_shift;
    logic   count_dec;
    oid_t   new_id;
    price_t new_price;
    qty_t   new_qty;

    // best price rescan
    logic   scan_start;
    logic   scan_step;
    logic   scan_done;

    // contents of the addressed slot
    oid_t   rd_id;
    price_t rd_price;
    qty_t   rd_qty;
    count_t count;

    modport ctrl (
        output side, stock, slot, wr_add, wr_dec, wr_shift, count_dec,
        output new_id, new_price, new_qty, scan_start, scan_step, scan_done,
        input  rd_id, rd_qty, count
    );

    modport store (
        input  side, stock, slot, wr_add, wr_dec, wr_shift, count_dec,
        input  new_id, new_price, new_qty,
        output rd_id, rd_price, rd_qty, count
    );

    modport scan (
        input side, stock, scan_start, scan_step, scan_done, rd_price
    );

endinterface

// File: logic/order_book_ctrl.sv
/* order book sequencer */
`timescale 1ns/100ps
`include "order_book_defs.svh"

module order_book_ctrl import order_book_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_order_valid,
    input  op_t     i_op,
    input  side_t   i_side,
    input  stock_t  i_stock,
    input  oid_t    i_order_id,
    input  price_t  i_price,
    input  qty_t    i_qty,
    input  logic    i_result_ready,
    output logic    o_ready,
    output logic    o_result_valid,
    output status_t o_status,
    book_if.ctrl    bif
);

    ctrl_state_t state_q, state_d;
    slot_t       slot_q, slot_d;
    status_t     status_q, status_d;

    // accepted order
    op_t    op_q;
    side_t  side_q;
    stock_t stock_q;
    oid_t   id_q;
    price_t price_q;
    qty_t   qty_q;

    count_t slot_ext;
    logic   last;
    logic   hit;
    logic   exec_all;

    assign o_ready        = (state_q == S_IDLE);
    assign o_result_valid = (state_q == S_DONE);
    assign o_status       = status_q;

    assign bif.side      = side_q;
    assign bif.stock     = stock_q;
    assign bif.slot      = slot_q;
    assign bif.new_id    = id_q;
    assign bif.new_price = price_q;
    assign bif.new_qty   = qty_q;

    assign slot_ext = {1'b0, slot_q};
    // also true on an empty side
    assign last     = (slot_ext + count_t'(1) >= bif.count);
    assign hit      = (bif.count != '0) && (bif.rd_id == id_q);
    assign exec_all = (qty_q >= bif.rd_qty);

    always_comb begin
        state_d        = state_q;
        slot_d         = slot_q;
        status_d       = status_q;
        bif.wr_add     = 1'b0;
        bif.wr_dec     = 1'b0;
        bif.wr_shift   = 1'b0;
        bif.count_dec  = 1'b0;
        bif.scan_start = 1'b0;
        bif.scan_step  = 1'b0;
        bif.scan_done  = 1'b0;
        case (state_q)
            S_IDLE: begin
                if (i_order_valid) begin
                    slot_d = '0;
                    case (i_op)
                        OP_ADD: state_d = S_ADD;
                        OP_CANCEL, OP_EXECUTE: state_d = S_SEARCH;
                        default: begin
                            status_d = ST_BAD_OP;
                            state_d  = S_DONE;
                        end
                    endcase
                end
            end
            S_ADD: begin
                if (bif.count == count_t'(`BOOK_DEPTH)) begin
                    status_d = ST_FULL;
                    state_d  = S_DONE;
                end else begin
                    bif.wr_add = 1'b1;
                    status_d   = ST_OK;
                    state_d    = S_SCAN;
                end
            end
            S_SEARCH: begin
                if (hit) begin
                    status_d = ST_OK;
                    if (op_q == OP_EXECUTE && !exec_all) begin
                        bif.wr_dec = 1'b1;
                        slot_d     = '0;
                        state_d    = S_SCAN;
                    end else if (last) begin
                        // nothing behind the removed order
                        bif.count_dec = 1'b1;
                        slot_d        = '0;
                        state_d       = S_SCAN;
                    end else begin
                        state_d = S_SHIFT;
                    end
                end else if (last) begin
                    status_d = ST_NOT_FOUND;
                    state_d  = S_DONE;
                end else begin
                    slot_d = slot_q + slot_t'(1);
                end
            end
            S_SHIFT: begin
                bif.wr_shift = 1'b1;
                if (slot_ext + count_t'(2) >= bif.count) begin
                    bif.count_dec = 1'b1;
                    slot_d        = '0;
                    state_d       = S_SCAN;
                end else begin
                    slot_d = slot_q + slot_t'(1);
                end
            end
            S_SCAN: begin
                bif.scan_start = (slot_q == '0);
                bif.scan_step  = (slot_ext < bif.count);
                bif.scan_done  = last;
                if (last) begin
                    state_d = S_DONE;
                end else begin
                    slot_d = slot_q + slot_t'(1);
                end
            end
            S_DONE: begin
                if (i_result_ready) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state_q  <= S_IDLE;
            slot_q   <= '0;
            status_q <= ST_OK;
        end else begin
            state_q  <= state_d;
            slot_q   <= slot_d;
            status_q <= status_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_ready && i_order_valid) begin
            op_q    <= i_op;
            side_q  <= i_side;
            stock_q <= i_stock;
            id_q    <= i_order_id;
            price_q <= i_price;
            qty_q   <= i_qty;
        end
    end

    a_valid_not_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(o_result_valid && o_ready));

    // search never runs past the packed part of the side
    a_search_in_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (state_q == S_SEARCH && bif.count != '0) |-> slot_ext < bif.count);

endmodule

// File: logic/book_store.sv
/* order storage */
`timescale 1ns/100ps
`include "order_book_defs.svh"

module book_store import order_book_pkg::*; (
    input  logic i_clk,
    input  logic i_reset_n,
    book_if.store bif
);

    // indexed by stock, side, slot
    oid_t   id_mem    [`NUM_STOCKS][2][`BOOK_DEPTH];
    price_t price_mem [`NUM_STOCKS][2][`BOOK_DEPTH];
    qty_t   qty_mem   [`NUM_STOCKS][2][`BOOK_DEPTH];

    count_t cnt_q [`NUM_STOCKS][2];

    count_t cur_cnt;
    slot_t  tail;
    slot_t  next_slot;

    assign cur_cnt   = cnt_q[bif.stock][bif.side];
    // append slot while the side has room
    assign tail      = slot_t'(cur_cnt);
    assign next_slot = bif.slot + slot_t'(1);

    assign bif.count    = cur_cnt;
    assign bif.rd_id    = id_mem[bif.stock][bif.side][bif.slot];
    assign bif.rd_price = price_mem[bif.stock][bif.side][bif.slot];
    assign bif.rd_qty   = qty_mem[bif.stock][bif.side][bif.slot];

    always_ff @(posedge i_clk) begin
        if (bif.wr_add) begin
            id_mem[bif.stock][bif.side][tail]    <= bif.new_id;
            price_mem[bif.stock][bif.side][tail] <= bif.new_price;
            qty_mem[bif.stock][bif.side][tail]   <= bif.new_qty;
        end
        // partial fill keeps the order in place
        if (bif.wr_dec) begin
            qty_mem[bif.stock][bif.side][bif.slot] <= bif.rd_qty - bif.new_qty;
        end
        // pull the next order forward one slot
        if (bif.wr_shift) begin
            id_mem[bif.stock][bif.side][bif.slot] <=
                id_mem[bif.stock][bif.side][next_slot];
            price_mem[bif.stock][bif.side][bif.slot] <=
                price_mem[bif.stock][bif.side][next_slot];
            qty_mem[bif.stock][bif.side][bif.slot] <=
                qty_mem[bif.stock][bif.side][next_slot];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < `NUM_STOCKS; s++) begin
                for (int d = 0; d < 2; d++) begin
                    cnt_q[s][d] <= '0;
                end
            end
        end else if (bif.wr_add) begin
            cnt_q[bif.stock][bif.side] <= cur_cnt + count_t'(1);
        end else if (bif.count_dec) begin
            cnt_q[bif.stock][bif.side] <= cur_cnt - count_t'(1);
        end
    end

    // the controller rejects adds to a full side
    a_no_add_when_full: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        bif.wr_add |-> cur_cnt != count_t'(`BOOK_DEPTH));

endmodule

// File: logic/best_price_scan.sv
/* best price search */
`timescale 1ns/100ps
`include "order_book_defs.svh"

module best_price_scan import order_book_pkg::*; (
    input  logic   i_clk,
    input  logic   i_reset_n,
    book_if.scan   bif,
    output price_t o_best_bid,
    output price_t o_best_ask
);

    localparam price_t BID_EMPTY = '0;
    localparam price_t ASK_EMPTY = {`PRICE_W{1'b1}};

    price_t best_bid_q [`NUM_STOCKS];
    price_t best_ask_q [`NUM_STOCKS];

    price_t run_best;
    price_t base;
    price_t cand;
    logic   better;

    // restart from the empty value of the scanned side
    assign base   = bif.scan_start ? ((bif.side == SIDE_BID) ? BID_EMPTY : ASK_EMPTY)
                                   : run_best;
    assign better = (bif.side == SIDE_BID) ? (bif.rd_price > base) : (bif.rd_price < base);
    assign cand   = (bif.scan_step && better) ? bif.rd_price : base;

    always_ff @(posedge i_clk) begin
        if (bif.scan_start || bif.scan_step) begin
            run_best <= cand;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            for (int s = 0; s < `NUM_STOCKS; s++) begin
                best_bid_q[s] <= BID_EMPTY;
                best_ask_q[s] <= ASK_EMPTY;
            end
        end else if (bif.scan_done) begin
            // cand already includes the final slot
            if (bif.side == SIDE_BID) begin
                best_bid_q[bif.stock] <= cand;
            end else begin
                best_ask_q[bif.stock] <= cand;
            end
        end
    end

    assign o_best_bid = best_bid_q[bif.stock];
    assign o_best_ask = best_ask_q[bif.stock];

endmodule

// File: logic/order_book_top.sv
/* limit order book top */
`timescale 1ns/100ps

module order_book_top import order_book_pkg::*; (
    input  logic    i_clk,
    input  logic    i_reset_n,
    input  logic    i_order_valid,
    input  op_t     i_op,
    input  side_t   i_side,
    input  stock_t  i_stock,
    input  oid_t    i_order_id,
    input  price_t  i_price,
    input  qty_t    i_qty,
    input  logic    i_result_ready,
    output logic    o_ready,
    output logic    o_result_valid,
    output status_t o_status,
    output price_t  o_best_bid,
    output price_t  o_best_ask
);

    book_if bif ();

    order_book_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_order_valid  (i_order_valid),
        .i_op           (i_op),
        .i_side         (i_side),
        .i_stock        (i_stock),
        .i_order_id     (i_order_id),
        .i_price        (i_price),
        .i_qty          (i_qty),
        .i_result_ready (i_result_ready),
        .o_ready        (o_ready),
        .o_result_valid (o_result_valid),
        .o_status       (o_status),
        .bif            (bif.ctrl)
    );

    book_store u_store (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .bif       (bif.store)
    );

    best_price_scan u_scan (
        .i_clk      (i_clk),
        .i_reset_n  (i_reset_n),
        .bif        (bif.scan),
        .o_best_bid (o_best_bid),
        .o_best_ask (o_best_ask)
    );

endmodule

// File: dv/order_book_tb.sv
/* order book testbench */
`timescale 1ns/100ps
`include "order_book_defs.svh"

module order_book_tb import order_book_pkg::*; ();

    localparam int WAIT_LIMIT = 200;

    logic    i_clk;
    logic    i_reset_n;
    logic    i_order_valid;
    op_t     i_op;
    side_t   i_side;
    stock_t  i_stock;
    oid_t    i_order_id;
    price_t  i_price;
    qty_t    i_qty;
    logic    i_result_ready;
    logic    o_ready;
    logic    o_result_valid;
    status_t o_status;
    price_t  o_best_bid;
    price_t  o_best_ask;

    // resting orders, packed the same way as the book
    oid_t   m_id    [`NUM_STOCKS][2][`BOOK_DEPTH];
    price_t m_price [`NUM_STOCKS][2][`BOOK_DEPTH];
    qty_t   m_qty   [`NUM_STOCKS][2][`BOOK_DEPTH];
    int     m_cnt   [`NUM_STOCKS][2];

    status_t     exp_status;
    price_t      exp_bid;
    price_t      exp_ask;
    logic        result_checked = 1'b0;
    int          stim_errors = 0;
    int          stim_checks = 0;
    int          cmp_errors = 0;
    int          cmp_checks = 0;
    int          mark = 0;
    oid_t        next_id = 1;
    int unsigned seed_draw;

    order_book_top uut (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic price_t best_price(input stock_t s, input side_t d);
        price_t best;
        best = (d == SIDE_BID) ? '0 : {`PRICE_W{1'b1}};
        for (int k = 0; k < m_cnt[s][d]; k++) begin
            if (d == SIDE_BID && m_price[s][d][k] > best) begin
                best = m_price[s][d][k];
            end
            if (d == SIDE_ASK && m_price[s][d][k] < best) begin
                best = m_price[s][d][k];
            end
        end
        return best;
    endfunction

    function automatic oid_t best_id(input stock_t s, input side_t d);
        oid_t id;
        id = '0;
        for (int k = m_cnt[s][d] - 1; k >= 0; k--) begin
            if (m_price[s][d][k] == best_price(s, d)) begin
                id = m_id[s][d][k];
            end
        end
        return id;
    endfunction

    // applies one order to the model and returns its status
    function automatic status_t apply_order(input op_t op, input side_t d, input stock_t s,
                                            input oid_t id, input price_t p, input qty_t q);
        int hit;
        hit = -1;
        if (op == OP_ADD) begin
            if (m_cnt[s][d] == `BOOK_DEPTH) begin
                return ST_FULL;
            end
            m_id[s][d][m_cnt[s][d]]    = id;
            m_price[s][d][m_cnt[s][d]] = p;
            m_qty[s][d][m_cnt[s][d]]   = q;
            m_cnt[s][d] = m_cnt[s][d] + 1;
            return ST_OK;
        end
        if (op != OP_CANCEL && op != OP_EXECUTE) begin
            return ST_BAD_OP;
        end
        for (int k = 0; k < m_cnt[s][d]; k++) begin
            if (hit < 0 && m_id[s][d][k] == id) begin
                hit = k;
            end
        end
        if (hit < 0) begin
            return ST_NOT_FOUND;
        end
        if (op == OP_EXECUTE && q < m_qty[s][d][hit]) begin
            m_qty[s][d][hit] = m_qty[s][d][hit] - q;
            return ST_OK;
        end
        for (int k = hit; k < m_cnt[s][d] - 1; k++) begin
            m_id[s][d][k]    = m_id[s][d][k + 1];
            m_price[s][d][k] = m_price[s][d][k + 1];
            m_qty[s][d][k]   = m_qty[s][d][k + 1];
        end
        m_cnt[s][d] = m_cnt[s][d] - 1;
        return ST_OK;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error at %0t: %s = %0h, expected %0h", $time, name, got, exp);
    endtask

    task automatic send_order(input op_t op, input side_t d, input stock_t s, input oid_t id,
                              input price_t p, input qty_t q, input int hold);
        int      n;
        status_t held_status;
        price_t  held_bid;
        price_t  held_ask;
        n = 0;
        while (!o_ready && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_ready) begin
            $display("timeout: the DUT never raised o_ready");
            $display("Finished with errors");
            $finish;
        end
        exp_status     = apply_order(op, d, s, id, p, q);
        exp_bid        = best_price(s, SIDE_BID);
        exp_ask        = best_price(s, SIDE_ASK);
        i_order_valid  = 1'b1;
        i_op           = op;
        i_side         = d;
        i_stock        = s;
        i_order_id     = id;
        i_price        = p;
        i_qty          = q;
        @(negedge i_clk);
        i_order_valid = 1'b0;
        n = 0;
        while (!o_result_valid && n < WAIT_LIMIT) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_result_valid) begin
            $display("timeout: the DUT never raised o_result_valid");
            $display("Finished with errors");
            $finish;
        end
        held_status = o_status;
        held_bid    = o_best_bid;
        held_ask    = o_best_ask;
        // result stays put while the consumer stalls
        for (int k = 0; k < hold; k++) begin
            @(negedge i_clk);
            stim_checks++;
            if (o_result_valid !== 1'b1) begin
                stim_errors++;
                report_mismatch("o_result_valid", 64'(o_result_valid), 64'(1));
            end
            if (o_ready !== 1'b0) begin
                stim_errors++;
                report_mismatch("o_ready", 64'(o_ready), 64'(0));
            end
            if (o_status != held_status) begin
                stim_errors++;
                report_mismatch("o_status", 64'(o_status), 64'(held_status));
            end
            if (o_best_bid != held_bid) begin
                stim_errors++;
                report_mismatch("o_best_bid", 64'(o_best_bid), 64'(held_bid));
            end
            if (o_best_ask != held_ask) begin
                stim_errors++;
                report_mismatch("o_best_ask", 64'(o_best_ask), 64'(held_ask));
            end
        end
        i_result_ready = 1'b1;
        @(negedge i_clk);
        i_result_ready = 1'b0;
    endtask

    task automatic add_random(input side_t d, input stock_t s, input int hold);
        send_order(OP_ADD, d, s, next_id, price_t'(1000 + $urandom % 9000),
                   qty_t'(10 + $urandom % 990), hold);
        next_id++;
    endtask

    task automatic finish_test(input string name);
        $display("%-28s %0d errors", name, stim_errors + cmp_errors - mark);
        mark = stim_errors + cmp_errors;
    endtask

    // checks each result once at the first falling edge it is valid
    always @(negedge i_clk) begin
        if (i_reset_n && o_result_valid && !result_checked) begin
            result_checked = 1'b1;
            cmp_checks++;
            if (o_status != exp_status) begin
                cmp_errors++;
                report_mismatch("o_status", 64'(o_status), 64'(exp_status));
            end
            if (o_best_bid != exp_bid) begin
                cmp_errors++;
                report_mismatch("o_best_bid", 64'(o_best_bid), 64'(exp_bid));
            end
            if (o_best_ask != exp_ask) begin
                cmp_errors++;
                report_mismatch("o_best_ask", 64'(o_best_ask), 64'(exp_ask));
            end
        end else if (!o_result_valid) begin
            result_checked = 1'b0;
        end
    end

    initial begin
        oid_t   id;
        qty_t   q;
        stock_t st;
        side_t  d;
        op_t    op;
        int     r;
        int     hold;
        int     slot;
        seed_draw      = $urandom(32'ha38);
        i_reset_n      = 1'b0;
        i_order_valid  = 1'b0;
        i_op           = OP_ADD;
        i_side         = SIDE_ASK;
        i_stock        = '0;
        i_order_id     = '0;
        i_price        = '0;
        i_qty          = '0;
        i_result_ready = 1'b0;
        repeat (3) @(negedge i_clk);
        i_reset_n = 1'b1;

        stim_checks += 2;
        if (o_ready !== 1'b1) begin
            stim_errors++;
            report_mismatch("o_ready", 64'(o_ready), 64'(1));
        end
        if (o_result_valid !== 1'b0) begin
            stim_errors++;
            report_mismatch("o_result_valid", 64'(o_result_valid), 64'(0));
        end
        for (int k = 0; k < `NUM_STOCKS; k++) begin
            send_order(op_t'(2'd3), SIDE_BID, stock_t'(k), '0, '0, '0, 0);
        end
        finish_test("reset and bad op");

        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 4; j++) begin
                add_random(SIDE_BID, stock_t'(k), 0);
                add_random(SIDE_ASK, stock_t'(k), 0);
            end
        end
        finish_test("adds");

        send_order(OP_CANCEL, SIDE_BID, 2'd0, best_id(2'd0, SIDE_BID), '0, '0, 0);
        send_order(OP_CANCEL, SIDE_ASK, 2'd1, best_id(2'd1, SIDE_ASK), '0, '0, 0);
        send_order(OP_CANCEL, SIDE_BID, 2'd2, m_id[2][SIDE_BID][1], '0, '0, 0);
        send_order(OP_CANCEL, SIDE_ASK, 2'd2, 32'hffff_fff0, '0, '0, 0);
        send_order(OP_CANCEL, SIDE_BID, 2'd3, 32'hffff_fff1, '0, '0, 0);
        finish_test("cancels");

        id = m_id[1][SIDE_BID][0];
        q  = m_qty[1][SIDE_BID][0];
        send_order(OP_EXECUTE, SIDE_BID, 2'd1, id, '0, q >> 1, 0);
        send_order(OP_EXECUTE, SIDE_BID, 2'd1, id, '0, m_qty[1][SIDE_BID][0], 0);
        // already gone after the second fill
        send_order(OP_CANCEL, SIDE_BID, 2'd1, id, '0, '0, 0);
        for (int k = 0; k <= `BOOK_DEPTH; k++) begin
            add_random(SIDE_ASK, 2'd3, 0);
        end
        finish_test("executes and full side");

        for (int k = 0; k < 4; k++) begin
            hold = 1 + $urandom % 10;
            add_random(SIDE_BID, 2'd3, hold);
        end
        finish_test("back-pressure");

        for (int n = 0; n < 300; n++) begin
            r    = $urandom % 10;
            st   = stock_t'($urandom % `NUM_STOCKS);
            d    = ($urandom % 2 == 0) ? SIDE_ASK : SIDE_BID;
            hold = $urandom % 4;
            if (r == 0) begin
                send_order(op_t'(2'd3), d, st, '0, '0, '0, hold);
            end else if (r < 5) begin
                add_random(d, st, hold);
            end else begin
                op = (r < 8) ? OP_CANCEL : OP_EXECUTE;
                id = oid_t'(32'hf000_0000 + $urandom % 4096);
                if (m_cnt[st][d] > 0 && $urandom % 4 != 0) begin
                    slot = $urandom % m_cnt[st][d];
                    id   = m_id[st][d][slot];
                end
                send_order(op, d, st, id, '0, qty_t'(1 + $urandom % 600), hold);
            end
        end
        finish_test("random mix");

        $display("tests: 6, checks: %0d, errors: %0d", stim_checks + cmp_checks,
                 stim_errors + cmp_errors);
        if (stim_errors + cmp_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+logic
logic/order_book_pkg.sv
logic/book_if.sv
logic/order_book_ctrl.sv
logic/book_store.sv
logic/best_price_scan.sv
logic/order_book_top.sv
dv/order_book_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the order book testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f src.f --top-module order_book_tb -o order_book_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/order_book_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
    exit 0
fi
echo "pass message not found in the simulation output"
exit 1
